// ==== design/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

`default_nettype none

// cache line index, virtual address bits 9..2
`define CACHE_IDX_BITS 8

// TLB index, virtual address bits 17..10
`define TLB_IDX_BITS 8

`define VTAG_BITS 14      // virtual address bits 31..18
`define PTAG_BITS 14      // physical page tag held in the TLB
`define CTAG_BITS 22      // physical address bits 31..10

// word address to external memory, physical address bits 27..2
`define MEM_ADDR_BITS 26

`default_nettype wire

`endif

// ==== design/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  // cache controller sequence, a hit or a fault never leaves IDLE
  typedef enum logic [1:0] {
    IDLE,
    MISS_WAIT,
    WRITE_WAIT,
    FILL_DONE
  } ctrl_state_e;

  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_op_e;

  // memory sequencer states
  // SEQ_IDLE is named apart from the controller's IDLE since both share this scope
  typedef enum logic [1:0] {
    SEQ_IDLE,
    DMA_HOLD,    // waits for the bus, also the cycle in which the strobe is raised
    ACTIVE
  } mem_state_e;

endpackage

`default_nettype wire

// ==== design/sync_ram.sv ====
`default_nettype none

module sync_ram #(
  parameter int WIDTH      = 32,
  parameter int DEPTH_BITS = 8
) (
  input  wire                  CPU_CLK,
  input  wire [DEPTH_BITS-1:0] raddr,
  output logic [WIDTH-1:0]     rdata,
  input  wire                  we,
  input  wire [DEPTH_BITS-1:0] waddr,
  input  wire [WIDTH-1:0]      wdata
);

  localparam int DEPTH = 1 << DEPTH_BITS;

  logic [WIDTH-1:0] mem [0:DEPTH-1];

  // read and write share the edge, so a colliding read sees the old word
  always_ff @(posedge CPU_CLK)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// ==== design/tlb_unit.sv ====
`include "cache_config.svh"
`default_nettype none

module tlb_unit (
  input  wire                   CPU_CLK,
  input  wire                   RST,
  input  wire [31:0]            precycle_addr,
  input  wire [31:0]            cycle_addr,
  input  wire                   tlb_wr,
  input  wire [31:0]            wr_data,
  output logic [`PTAG_BITS-1:0] ptag,
  output logic                  fault
);

  localparam int ENTRY_BITS = `PTAG_BITS + `VTAG_BITS;
  localparam int IDX_LSB    = `CACHE_IDX_BITS + 2;
  localparam int DEPTH      = 1 << `TLB_IDX_BITS;

  logic [`TLB_IDX_BITS-1:0] rd_idx;
  logic [`TLB_IDX_BITS-1:0] wr_idx;
  logic [ENTRY_BITS-1:0]    wr_entry;
  logic [ENTRY_BITS-1:0]    ram_entry;
  logic [ENTRY_BITS-1:0]    byp_entry;
  logic [ENTRY_BITS-1:0]    entry;
  logic [`VTAG_BITS-1:0]    vtag;
  logic [DEPTH-1:0]         valid_bits;
  logic                     valid_q;
  logic                     byp_q;
  logic                     same_idx;

  assign rd_idx   = precycle_addr[IDX_LSB +: `TLB_IDX_BITS];
  assign wr_idx   = cycle_addr[IDX_LSB +: `TLB_IDX_BITS];
  assign wr_entry = {wr_data[16 +: `PTAG_BITS], wr_data[0 +: `VTAG_BITS]};
  assign same_idx = tlb_wr && (rd_idx == wr_idx);

  // an access that follows a TLB write to its own entry sees the new pair
  assign entry = byp_q ? byp_entry : ram_entry;
  assign ptag  = entry[ENTRY_BITS-1 -: `PTAG_BITS];
  assign vtag  = entry[`VTAG_BITS-1:0];
  assign fault = !valid_q || (vtag != cycle_addr[31 -: `VTAG_BITS]);

  sync_ram #(
    .WIDTH      (ENTRY_BITS),
    .DEPTH_BITS (`TLB_IDX_BITS)
  ) tlb_ram_i (
    .CPU_CLK (CPU_CLK),
    .raddr   (rd_idx),
    .rdata   (ram_entry),
    .we      (tlb_wr),
    .waddr   (wr_idx),
    .wdata   (wr_entry)
  );

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid_bits <= '0;    // every entry faults until the CPU loads it
      valid_q    <= 1'b0;
      byp_q      <= 1'b0;
    end
    else
    begin
      if (tlb_wr)
      begin
        valid_bits[wr_idx] <= 1'b1;
      end
      valid_q <= valid_bits[rd_idx] || same_idx;
      byp_q   <= same_idx;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    byp_entry <= wr_entry;
  end

endmodule

`default_nettype wire

// ==== design/mem_port.sv ====
`include "cache_config.svh"
`default_nettype none

module mem_port (
  input  wire                       CPU_CLK,
  input  wire                       RST,
  input  wire                       req,
  input  wire cache_pkg::mem_op_e   op,
  input  wire [31:0]                phys_addr,
  input  wire [31:0]                wdata,
  output logic                      done,
  output logic [31:0]               rdata,
  input  wire                       dma_mcu_access,
  output logic [`MEM_ADDR_BITS-1:0] mem_addr,
  output logic                      mem_we,
  output logic                      mem_do_act,
  output logic [31:0]               mem_dataintomem,
  input  wire                       mem_ack,
  input  wire [31:0]                mem_datafrommem
);
  import cache_pkg::*;

  mem_state_e state;
  logic       granted;
  logic       finish;

  // the strobe comes up in the same cycle the DMA master lets go of the bus,
  // and once up it is held through ACTIVE whatever DMA does next
  assign granted    = (state == ACTIVE) || ((state == DMA_HOLD) && !dma_mcu_access);
  assign mem_do_act = granted;
  assign finish     = granted && mem_ack;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state  <= SEQ_IDLE;
      mem_we <= 1'b0;
      done   <= 1'b0;
    end
    else
    begin
      done <= finish;    // one cycle pulse back to the controller
      case (state)
        SEQ_IDLE:
        begin
          if (req)
          begin
            mem_we <= (op == MEM_WRITE);
            state  <= DMA_HOLD;
          end
        end
        DMA_HOLD:
        begin
          if (finish)
            state <= SEQ_IDLE;
          else if (!dma_mcu_access)
            state <= ACTIVE;
        end
        ACTIVE:
        begin
          if (finish)
            state <= SEQ_IDLE;
        end
        default: state <= SEQ_IDLE;
      endcase
      if (finish)
      begin
        mem_we <= 1'b0;
      end
    end
  end

  // address and write word are latched with the request and stay put until ack
  always_ff @(posedge CPU_CLK)
  begin
    if ((state == SEQ_IDLE) && req)
    begin
      mem_addr        <= phys_addr[`MEM_ADDR_BITS+1:2];
      mem_dataintomem <= wdata;
    end
    if (finish && !mem_we)
    begin
      rdata <= mem_datafrommem;
    end
  end

endmodule

`default_nettype wire

// ==== design/cache_ctrl.sv ====
`include "cache_config.svh"
`default_nettype none

module cache_ctrl (
  input  wire                   CPU_CLK,
  input  wire                   RST,
  input  wire [31:0]            precycle_addr,
  input  wire [31:0]            cycle_addr,
  input  wire                   cycle_enable,
  input  wire                   cycle_we,
  input  wire [31:0]            datao,
  input  wire [`PTAG_BITS-1:0]  ptag,
  input  wire                   fault,
  output logic [31:0]           datai,
  output logic                  busy,
  output logic                  req,
  output cache_pkg::mem_op_e    op,
  output logic [31:0]           phys_addr,
  output logic [31:0]           wdata,
  input  wire                   done,
  input  wire [31:0]            rdata
);
  import cache_pkg::*;

  localparam int IDX_LSB   = 2;
  localparam int PAGE_LSB  = `CACHE_IDX_BITS + IDX_LSB;
  localparam int PAGE_BITS = `CTAG_BITS - `PTAG_BITS;
  localparam int LINES     = 1 << `CACHE_IDX_BITS;

  ctrl_state_e                state;
  ctrl_state_e                next_state;
  logic [`CACHE_IDX_BITS-1:0] rd_idx;
  logic [`CACHE_IDX_BITS-1:0] wr_idx;
  logic [`CTAG_BITS-1:0]      ctag;
  logic [`CTAG_BITS-1:0]      tag_rdata;
  logic [31:0]                data_rdata;
  logic [LINES-1:0]           line_valid;
  logic                       line_valid_q;
  logic                       hit;
  logic                       access;
  logic                       start_write;
  logic                       start_miss;
  logic                       fill;
  logic                       ram_we;
  logic [31:0]                ram_wdata;
  logic [31:0]                fill_q;

  assign rd_idx    = precycle_addr[IDX_LSB +: `CACHE_IDX_BITS];
  assign wr_idx    = cycle_addr[IDX_LSB +: `CACHE_IDX_BITS];
  assign ctag      = {ptag, cycle_addr[PAGE_LSB +: PAGE_BITS]};
  assign phys_addr = {ptag, cycle_addr[31-`PTAG_BITS:0]};
  assign wdata     = datao;
  assign op        = cycle_we ? MEM_WRITE : MEM_READ;

  assign hit    = line_valid_q && (tag_rdata == ctag);
  assign access = (state == IDLE) && cycle_enable && !fault;

  assign start_write = access && cycle_we;
  assign start_miss  = access && !cycle_we && !hit;
  assign req         = start_write || start_miss;
  assign fill        = (state == MISS_WAIT) && done;

  // write-through puts the word in the line as the memory write is issued
  assign ram_we    = start_write || fill;
  assign ram_wdata = fill ? rdata : datao;

  assign datai = (state == FILL_DONE) ? fill_q : data_rdata;

  sync_ram #(
    .WIDTH      (32),
    .DEPTH_BITS (`CACHE_IDX_BITS)
  ) data_ram_i (
    .CPU_CLK (CPU_CLK),
    .raddr   (rd_idx),
    .rdata   (data_rdata),
    .we      (ram_we),
    .waddr   (wr_idx),
    .wdata   (ram_wdata)
  );

  sync_ram #(
    .WIDTH      (`CTAG_BITS),
    .DEPTH_BITS (`CACHE_IDX_BITS)
  ) tag_ram_i (
    .CPU_CLK (CPU_CLK),
    .raddr   (rd_idx),
    .rdata   (tag_rdata),
    .we      (ram_we),
    .waddr   (wr_idx),
    .wdata   (ctag)
  );

  always_comb
  begin
    next_state = state;
    busy       = 1'b0;
    case (state)
      IDLE:
      begin
        busy = req;
        if (start_write)
          next_state = WRITE_WAIT;
        else if (start_miss)
          next_state = MISS_WAIT;
      end
      MISS_WAIT:
      begin
        busy = 1'b1;    // stays up through the fill cycle
        if (done)
          next_state = FILL_DONE;
      end
      WRITE_WAIT:
      begin
        busy = !done;
        if (done)
          next_state = IDLE;
      end
      FILL_DONE: next_state = IDLE;    // word comes from fill_q here
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state        <= IDLE;
      line_valid   <= '0;
      line_valid_q <= 1'b0;
    end
    else
    begin
      state        <= next_state;
      line_valid_q <= line_valid[rd_idx];
      if (ram_we)
      begin
        line_valid[wr_idx] <= 1'b1;
      end
    end
  end

  // the RAM read in the fill cycle still returns the old word
  always_ff @(posedge CPU_CLK)
  begin
    if (fill)
    begin
      fill_q <= rdata;
    end
  end

endmodule

`default_nettype wire

// ==== design/cache_top.sv ====
`include "cache_config.svh"
`default_nettype none

module cache_top (
  input  wire                       CPU_CLK,
  input  wire                       RST,
  input  wire [31:0]                precycle_addr,
  input  wire                       precycle_enable,   // unused, kept for the CPU port
  input  wire [31:0]                cycle_addr,
  input  wire                       cycle_enable,
  input  wire                       cycle_we,
  input  wire                       tlb_we,
  input  wire [31:0]                datao,
  output logic [31:0]               datai,
  output logic                      busy,
  output logic                      fault,
  input  wire                       dma_mcu_access,
  output logic [`MEM_ADDR_BITS-1:0] mem_addr,
  output logic                      mem_we,
  output logic                      mem_do_act,
  output logic [31:0]               mem_dataintomem,
  input  wire                       mem_ack,
  input  wire [31:0]                mem_datafrommem
);
  import cache_pkg::*;

  logic                  tlb_wr;
  logic                  access_en;
  logic                  tlb_fault;
  logic [`PTAG_BITS-1:0] tlb_ptag;
  logic                  mem_req;
  mem_op_e               mem_op;
  logic [31:0]           mem_paddr;
  logic [31:0]           mem_wdata;
  logic                  mem_done;
  logic [31:0]           mem_rdata;

  // a TLB write cycle is not a cache access
  assign tlb_wr    = cycle_enable && tlb_we;
  assign access_en = cycle_enable && !tlb_we;
  assign fault     = tlb_fault && access_en;

  tlb_unit tlb_i (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .precycle_addr (precycle_addr),
    .cycle_addr    (cycle_addr),
    .tlb_wr        (tlb_wr),
    .wr_data       (datao),
    .ptag          (tlb_ptag),
    .fault         (tlb_fault)
  );

  cache_ctrl ctrl_i (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .precycle_addr (precycle_addr),
    .cycle_addr    (cycle_addr),
    .cycle_enable  (access_en),
    .cycle_we      (cycle_we),
    .datao         (datao),
    .ptag          (tlb_ptag),
    .fault         (fault),
    .datai         (datai),
    .busy          (busy),
    .req           (mem_req),
    .op            (mem_op),
    .phys_addr     (mem_paddr),
    .wdata         (mem_wdata),
    .done          (mem_done),
    .rdata         (mem_rdata)
  );

  mem_port mem_i (
    .CPU_CLK         (CPU_CLK),
    .RST             (RST),
    .req             (mem_req),
    .op              (mem_op),
    .phys_addr       (mem_paddr),
    .wdata           (mem_wdata),
    .done            (mem_done),
    .rdata           (mem_rdata),
    .dma_mcu_access  (dma_mcu_access),
    .mem_addr        (mem_addr),
    .mem_we          (mem_we),
    .mem_do_act      (mem_do_act),
    .mem_dataintomem (mem_dataintomem),
    .mem_ack         (mem_ack),
    .mem_datafrommem (mem_datafrommem)
  );

endmodule

`default_nettype wire

// ==== bench/cache_chk.sv ====
`include "cache_config.svh"
`default_nettype none

module cache_chk (
  input wire                       CPU_CLK,
  input wire                       RST,
  input wire                       busy,
  input wire                       fault,
  input wire                       dma_mcu_access,
  input wire                       mem_do_act,
  input wire                       mem_we,
  input wire [`MEM_ADDR_BITS-1:0]  mem_addr,
  input wire cache_pkg::ctrl_state_e ctrl_state
);
  import cache_pkg::*;

  int violations = 0;

  // the strobe may only come up once the DMA master has let go of the bus
  dma_holdoff: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $rose(mem_do_act) |-> !dma_mcu_access)
    else begin $error("memory strobe rose while dma_mcu_access was high"); violations++; end

  strobe_stable: assert property (@(posedge CPU_CLK) disable iff (!RST)
    mem_do_act && $past(mem_do_act) |-> $stable(mem_addr) && $stable(mem_we))
    else begin $error("mem_addr or mem_we changed during an access"); violations++; end

  reset_quiet: assert property (@(posedge CPU_CLK)
    !RST |=> !busy && !mem_do_act)
    else begin $error("busy or mem_do_act high after reset"); violations++; end

  // a request from the idle controller shows up as the strobe one cycle later
  fault_no_access: assert property (@(posedge CPU_CLK) disable iff (!RST)
    fault && (ctrl_state == IDLE) |=> !mem_do_act)
    else begin $error("memory access started for a faulting access"); violations++; end

endmodule

`default_nettype wire

// ==== bench/cache_tb.sv ====
`include "cache_config.svh"
`default_nettype none

module cache_tb;

  localparam int RESET_CYCLES = 8;
  localparam int ACCESS_COUNT = 113;    // every CPU cycle issued by the six tests

  logic                       CPU_CLK = 1'b0;
  logic                       RST = 1'b0;
  logic [31:0]                precycle_addr = '0;
  logic                       precycle_enable = 1'b0;
  logic [31:0]                cycle_addr = '0;
  logic                       cycle_enable = 1'b0;
  logic                       cycle_we = 1'b0;
  logic                       tlb_we = 1'b0;
  logic [31:0]                datao = '0;
  logic [31:0]                datai;
  logic                       busy;
  logic                       fault;
  logic                       dma_mcu_access = 1'b0;
  logic [`MEM_ADDR_BITS-1:0]  mem_addr;
  logic                       mem_we;
  logic                       mem_do_act;
  logic [31:0]                mem_dataintomem;
  logic                       mem_ack = 1'b0;
  logic [31:0]                mem_datafrommem = '0;

  int stim_seed = 2;
  int delay_seed = 2;
  int errors = 0;
  int test_base = 0;
  int tests_run = 0;
  int tests_failed = 0;

  logic [31:0] model_mem [logic [`MEM_ADDR_BITS-1:0]];    // what the memory holds
  logic [31:0] expect_mem [logic [`MEM_ADDR_BITS-1:0]];   // what the bench believes was written
  logic [13:0] tlb_ptag [0:255];
  logic [13:0] page_vtag [0:2];
  logic [7:0]  page_tidx [0:2];
  logic [13:0] page_ptag [0:2];

  logic                      last_act;
  logic [`MEM_ADDR_BITS-1:0] last_act_addr;
  logic                      last_act_we;
  logic                      model_armed = 1'b0;
  int                        wait_cnt = 0;

  always #10 CPU_CLK = ~CPU_CLK;

  cache_top dut_i (
    .CPU_CLK         (CPU_CLK),
    .RST             (RST),
    .precycle_addr   (precycle_addr),
    .precycle_enable (precycle_enable),
    .cycle_addr      (cycle_addr),
    .cycle_enable    (cycle_enable),
    .cycle_we        (cycle_we),
    .tlb_we          (tlb_we),
    .datao           (datao),
    .datai           (datai),
    .busy            (busy),
    .fault           (fault),
    .dma_mcu_access  (dma_mcu_access),
    .mem_addr        (mem_addr),
    .mem_we          (mem_we),
    .mem_do_act      (mem_do_act),
    .mem_dataintomem (mem_dataintomem),
    .mem_ack         (mem_ack),
    .mem_datafrommem (mem_datafrommem)
  );

  bind cache_top cache_chk chk_i (
    .CPU_CLK        (CPU_CLK),
    .RST            (RST),
    .busy           (busy),
    .fault          (fault),
    .dma_mcu_access (dma_mcu_access),
    .mem_do_act     (mem_do_act),
    .mem_we         (mem_we),
    .mem_addr       (mem_addr),
    .ctrl_state     (ctrl_i.state)
  );

  function automatic logic [31:0] pattern(input logic [`MEM_ADDR_BITS-1:0] w);
    return {6'b0, w} ^ 32'hC3A5_0F96;
  endfunction

  function automatic logic [31:0] make_addr(input logic [13:0] vtag, input logic [7:0] tidx,
                                            input logic [7:0] cidx);
    return {vtag, tidx, cidx, 2'b00};
  endfunction

  // word address the access should reach, taken from the bench's own copy of the TLB
  function automatic logic [`MEM_ADDR_BITS-1:0] phys_word(input logic [31:0] addr);
    logic [13:0] ptag;
    ptag = tlb_ptag[addr[17:10]];
    return {ptag[9:0], addr[17:2]};
  endfunction

  function automatic logic [31:0] expected_word(input logic [`MEM_ADDR_BITS-1:0] w);
    if (expect_mem.exists(w))
      return expect_mem[w];
    return pattern(w);
  endfunction

  // memory acknowledges 1 to 4 cycles after the strobe comes up
  always @(posedge CPU_CLK)
  begin
    mem_ack <= 1'b0;
    if (!RST)
    begin
      model_armed = 1'b0;
    end
    else if (mem_do_act && !mem_ack)
    begin
      if (!model_armed)
      begin
        model_armed = 1'b1;
        wait_cnt = $random(delay_seed) & 3;
      end
      if (wait_cnt == 0)
      begin
        model_armed = 1'b0;
        mem_ack <= 1'b1;
        if (mem_we)
          model_mem[mem_addr] = mem_dataintomem;
        else if (model_mem.exists(mem_addr))
          mem_datafrommem <= model_mem[mem_addr];
        else
          mem_datafrommem <= pattern(mem_addr);
      end
      else
        wait_cnt = wait_cnt - 1;
    end
  end

  task automatic compare_word(input logic [31:0] got, input logic [31:0] exp, input string msg);
    assert (got === exp)
    else
    begin
      $display("FAIL at time %0t: %s, got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic verify(input logic ok, input string msg);
    assert (ok === 1'b1)
    else
    begin
      $display("FAIL at time %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic note_strobe();
    if (mem_do_act)
    begin
      last_act = 1'b1;
      last_act_addr = mem_addr;
      last_act_we = mem_we;
    end
  endtask

  // drives one CPU cycle and holds it while busy is high
  // outputs are sampled on the falling edge, and the strobe once more after the access ends
  task automatic cpu_access(input logic [31:0] addr, input logic we, input logic tlbw,
                            input logic [31:0] data, output logic [31:0] rd,
                            output logic flt, output int waits);
    waits = 0;
    last_act = 1'b0;
    @(posedge CPU_CLK);
    precycle_addr <= addr;
    precycle_enable <= 1'b1;
    @(posedge CPU_CLK);
    precycle_enable <= 1'b0;
    cycle_addr <= addr;
    cycle_enable <= 1'b1;
    cycle_we <= we;
    tlb_we <= tlbw;
    datao <= data;
    @(negedge CPU_CLK);
    flt = fault;
    note_strobe();
    while (busy)
    begin
      waits++;
      @(negedge CPU_CLK);
      note_strobe();
    end
    rd = datai;
    @(posedge CPU_CLK);
    cycle_enable <= 1'b0;
    cycle_we <= 1'b0;
    tlb_we <= 1'b0;
    @(negedge CPU_CLK);
    note_strobe();
  endtask

  task automatic load_tlb(input int p);
    logic [31:0] rd;
    logic        flt;
    int          waits;
    cpu_access(make_addr(14'h0, page_tidx[p], 8'h00), 1'b0, 1'b1,
               {2'b00, page_ptag[p], 2'b00, page_vtag[p]}, rd, flt, waits);
    tlb_ptag[page_tidx[p]] = page_ptag[p];
    verify(!flt && waits == 0 && !last_act, "TLB write raised fault, busy or a memory access");
  endtask

  task automatic read_expect(input logic [31:0] addr, input string what, output int waits);
    logic [31:0] rd;
    logic        flt;
    cpu_access(addr, 1'b0, 1'b0, 32'h0, rd, flt, waits);
    verify(!flt, "unexpected fault on a mapped read");
    compare_word(rd, expected_word(phys_word(addr)), what);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        flt;
    int          waits;
    cpu_access(addr, 1'b1, 1'b0, data, rd, flt, waits);
    verify(!flt && waits > 0, "write did not raise busy");
    expect_mem[phys_word(addr)] = data;
  endtask

  task automatic end_test(input string name);
    if (errors == test_base)
      $display("test %s: passed", name);
    else
    begin
      $display("test %s: failed with %0d errors", name, errors - test_base);
      tests_failed++;
    end
    tests_run++;
    test_base = errors;
  endtask

  initial
  begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rd;
    logic [31:0] r;
    logic [31:0] first;
    logic        flt;
    int          waits;
    int          p;

    page_vtag[0] = 14'h0012;
    page_tidx[0] = 8'h03;
    page_ptag[0] = 14'h0101;
    page_vtag[1] = 14'h0345;
    page_tidx[1] = 8'h05;
    page_ptag[1] = 14'h0202;
    page_vtag[2] = 14'h1ABC;
    page_tidx[2] = 8'h09;
    page_ptag[2] = 14'h0303;
    repeat (RESET_CYCLES) @(posedge CPU_CLK);
    RST <= 1'b1;

    for (int i = 0; i < 3; i++)
      load_tlb(i);
    cpu_access(make_addr(14'h0013, 8'h03, 8'h00), 1'b0, 1'b0, 32'h0, rd, flt, waits);
    verify(flt && waits == 0 && !last_act, "wrong virtual tag did not fault cleanly");
    cpu_access(make_addr(14'h0012, 8'h40, 8'h00), 1'b0, 1'b0, 32'h0, rd, flt, waits);
    verify(flt && waits == 0 && !last_act, "unloaded TLB entry did not fault cleanly");
    end_test("tlb load and fault");

    a = make_addr(page_vtag[0], page_tidx[0], 8'h10);
    read_expect(a, "read miss data", waits);
    verify(waits > 0 && last_act && !last_act_we, "first read did not go to memory");
    read_expect(a, "read hit data", waits);
    verify(waits == 0 && !last_act, "repeated read was not a hit");
    end_test("read miss then hit");

    a = make_addr(page_vtag[0], page_tidx[0], 8'h31);
    write_word(a, 32'hDEAD_BEEF);
    verify(last_act && last_act_we, "write did not strobe memory with mem_we high");
    compare_word({6'b0, last_act_addr}, {6'b0, phys_word(a)}, "write address");
    read_expect(a, "read after write", waits);
    verify(waits == 0, "read after write was not a hit");
    compare_word(model_mem.exists(phys_word(a)) ? model_mem[phys_word(a)] : 32'hx,
                 32'hDEAD_BEEF, "memory word after write-through");
    end_test("write-through");

    a = make_addr(page_vtag[0], page_tidx[0], 8'h20);
    b = make_addr(page_vtag[1], page_tidx[1], 8'h20);    // same line index under another tag
    read_expect(a, "first conflict read", waits);
    read_expect(b, "second conflict read", waits);
    verify(waits > 0, "second address hit a line it does not own");
    read_expect(a, "re-read after eviction", waits);
    verify(waits > 0, "evicted address still hit");
    end_test("conflict eviction");

    a = make_addr(page_vtag[2], page_tidx[2], 8'h05);
    @(posedge CPU_CLK);
    dma_mcu_access <= 1'b1;
    fork
      cpu_access(a, 1'b0, 1'b0, 32'h0, rd, flt, waits);
      begin
        do @(negedge CPU_CLK); while (!busy);
        repeat (5)
        begin
          verify(busy && !mem_do_act, "memory access started while the DMA master held the bus");
          @(negedge CPU_CLK);
        end
        @(posedge CPU_CLK);
        dma_mcu_access <= 1'b0;
      end
    join
    first = expected_word(phys_word(a));
    compare_word(rd, first, "read after DMA release");
    verify(!flt && waits > 5, "read finished while DMA held the bus");
    end_test("dma hold-off");

    for (int i = 0; i < 100; i++)
    begin
      r = $random(stim_seed);
      p = int'(r % 32'd3);
      a = make_addr(page_vtag[p], page_tidx[p], {4'h0, r[7:4]});
      if (r[8])
        write_word(a, $random(stim_seed));
      else
        read_expect(a, "random read", waits);
    end
    end_test("random mix");

    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, dut_i.chk_i.violations);
    if (errors == 0 && dut_i.chk_i.violations == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    repeat (RESET_CYCLES + 200 * ACCESS_COUNT) @(posedge CPU_CLK);
    $display("run timed out, the DUT stopped answering before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+design
design/cache_pkg.sv
design/sync_ram.sv
design/tlb_unit.sv
design/mem_port.sv
design/cache_ctrl.sv
design/cache_top.sv
bench/cache_chk.sv
bench/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the cache testbench with Verilator and runs it.
# The run counts as passed only when the testbench prints its pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module cache_tb \
  -f all.f \
  -o cache_sim

# keep going after a failing simulator so its output is still shown
output=$(./obj_dir/cache_sim 2>&1) || true
echo "$output"

if grep -Fxq "ALL TESTS PASSED" <<< "$output"; then
  exit 0
else
  exit 1
fi
